// ==== bench/fetch_unit_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_chk #(
    parameter int IF_WIDTH = 2
) (
    input logic             clk,
    input logic             rst,
    input logic             nxt_valid,
    input logic             nxt_ready,
    input fetch_pkg::addr_t pc,
    input fetch_pkg::inst_t insts [IF_WIDTH],
    input fetch_pkg::addr_t dfp_addr,
    input logic             dfp_read,
    input logic             dfp_resp
);
    import icache_pkg::*;

    int                     fail_count = 0;
    logic [IF_WIDTH*32-1:0] insts_flat;

    always_comb begin
        for (int i = 0; i < IF_WIDTH; i++) begin
            insts_flat[i*32 +: 32] = insts[i];
        end
    end

    // Nothing presented right after a reset cycle
    assert property (@(posedge clk) rst |=> !nxt_valid)
        else begin
            $error("nxt_valid high after reset");
            fail_count++;
        end

    // Group held by a stalled decode must not change
    assert property (@(posedge clk) disable iff (rst)
        (nxt_valid && !nxt_ready) |=> ($stable(pc) && $stable(insts_flat)))
        else begin
            $error("pc or insts changed while decode stalled");
            fail_count++;
        end

    // Line read held steady until memory answers
    assert property (@(posedge clk) disable iff (rst)
        (dfp_read && !dfp_resp) |=> (dfp_read && $stable(dfp_addr)))
        else begin
            $error("line read dropped or moved before dfp_resp");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (rst)
        dfp_read |-> (dfp_addr[OFFSET_BITS-1:0] == '0))
        else begin
            $error("dfp_addr not line aligned");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== bench/fetch_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_tb;
    import fetch_pkg::*;
    import icache_pkg::*;

    localparam int    IF_WIDTH     = 2;
    localparam addr_t RESET_PC     = 32'h0000_1000;
    localparam int    GROUP_BYTES  = IF_WIDTH * 4;
    localparam int    TOTAL_GROUPS = 40 + 40 + 60 + 8 + 12;

    logic  clk;
    logic  rst;
    logic  redirect;
    addr_t redirect_pc;
    logic  nxt_valid;
    logic  nxt_ready;
    addr_t pc;
    inst_t insts [IF_WIDTH];
    addr_t dfp_addr;
    logic  dfp_read;
    line_t dfp_rdata;
    logic  dfp_resp;

    integer seed = 32'hd62f0057;
    string  test_name = "reset";
    addr_t  exp_ptr = RESET_PC;
    int     groups_seen = 0;
    int     mem_reads = 0;
    int     errors = 0;
    int     tests_done = 0;
    int     err_base;
    int     group_base;

    fetch_unit #(
        .IF_WIDTH (IF_WIDTH),
        .SETS     (16),
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .nxt_valid   (nxt_valid),
        .nxt_ready   (nxt_ready),
        .pc          (pc),
        .insts       (insts),
        .dfp_addr    (dfp_addr),
        .dfp_read    (dfp_read),
        .dfp_rdata   (dfp_rdata),
        .dfp_resp    (dfp_resp)
    );

    bind fetch_unit fetch_unit_chk #(
        .IF_WIDTH (IF_WIDTH)
    ) i_chk (
        .clk       (clk),
        .rst       (rst),
        .nxt_valid (nxt_valid),
        .nxt_ready (nxt_ready),
        .pc        (pc),
        .insts     (insts),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_resp  (dfp_resp)
    );

    // Instruction stored at a byte address, every address bit matters
    function automatic inst_t word_at(input addr_t a);
        addr_t w;
        w = a * 32'h9e37_79b1;
        return w ^ (a >> 11) ^ 32'h5bd1_e995;
    endfunction

    function automatic addr_t group_of(input addr_t a);
        return a & ~addr_t'(GROUP_BYTES - 1);
    endfunction

    function automatic line_t line_at(input addr_t base);
        line_t l;
        for (int w = 0; w < LINE_WORDS; w++) begin
            l[w*32 +: 32] = word_at(base + addr_t'(4 * w));
        end
        return l;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Memory answers each line read after 2 to 9 cycles
    initial begin
        int    delay;
        addr_t line_addr;
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
        forever begin
            @(negedge clk);
            if (!rst && dfp_read) begin
                line_addr = dfp_addr;
                mem_reads++;
                delay = 2 + int'($unsigned($random(seed)) % 8);
                repeat (delay) @(posedge clk);
                #1;
                dfp_rdata = line_at(line_addr);
                dfp_resp  = 1'b1;
                @(posedge clk);
                #1;
                dfp_resp = 1'b0;
            end
        end
    end

    // Model pointer follows the expected pc, checked on every handshake
    initial begin
        addr_t exp_pc;
        inst_t exp_word;
        forever begin
            @(negedge clk);
            if (rst) begin
                exp_ptr = RESET_PC;
            end else if (redirect) begin
                exp_ptr = group_of(redirect_pc);
            end else if (nxt_valid && nxt_ready) begin
                exp_pc = exp_ptr;
                assert (pc == exp_pc) else begin
                    $display("ERR %s: pc expected %h actual %h", test_name, exp_pc, pc);
                    errors++;
                end
                for (int i = 0; i < IF_WIDTH; i++) begin
                    exp_word = word_at(exp_pc + addr_t'(4 * i));
                    assert (insts[i] == exp_word) else begin
                        $display("ERR %s: insts[%0d] expected %h actual %h",
                                 test_name, i, exp_word, insts[i]);
                        errors++;
                    end
                end
                exp_ptr = exp_pc + addr_t'(GROUP_BYTES);
                groups_seen++;
            end
        end
    end

    initial begin
        repeat (200 * TOTAL_GROUPS) @(posedge clk);
        $display("timeout: the fetch unit stopped delivering groups in test %s", test_name);
        $display("tests failed");
        $finish;
    end

    task automatic begin_test(input string name);
        test_name  = name;
        err_base   = errors;
        group_base = groups_seen;
    endtask

    task automatic end_test();
        $display("test %s: %0d groups, %0d errors",
                 test_name, groups_seen - group_base, errors - err_base);
        tests_done++;
    endtask

    task automatic send_redirect(input addr_t target);
        @(posedge clk);
        #1;
        redirect    = 1'b1;
        redirect_pc = target;
        @(posedge clk);
        #1;
        redirect = 1'b0;
    endtask

    // Take n groups, decode stalls at random when asked
    task automatic take_groups(input int n, input bit stall);
        int target;
        target = groups_seen + n;
        while (groups_seen < target) begin
            nxt_ready = stall ? (($random(seed) & 1) != 0) : 1'b1;
            @(posedge clk);
            #1;
        end
        nxt_ready = 1'b0;
    endtask

    // Stalled stage shows its group, so no miss is still running
    task automatic wait_idle();
        do begin
            @(negedge clk);
        end while (!nxt_valid);
        @(posedge clk);
        #1;
    endtask

    initial begin
        int mem_base;
        int total;
        rst         = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        nxt_ready   = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        begin_test("sequential");
        @(negedge clk);
        assert (!nxt_valid) else begin
            $display("test %s: a group was presented right after reset", test_name);
            errors++;
        end
        @(posedge clk);
        #1;
        take_groups(40, 1'b0);
        end_test();
        wait_idle();

        // Same addresses again, all lines already cached
        begin_test("refill_hits");
        mem_base = mem_reads;
        send_redirect(RESET_PC);
        take_groups(40, 1'b0);
        assert (mem_reads == mem_base) else begin
            $display("ERR %s: memory reads expected 0 actual %0d",
                     test_name, mem_reads - mem_base);
            errors++;
        end
        end_test();
        wait_idle();

        begin_test("backpressure");
        take_groups(60, 1'b1);
        end_test();
        wait_idle();

        begin_test("redirect_miss");
        send_redirect(32'h0000_3000);
        do begin
            @(negedge clk);
        end while (!dfp_read);
        send_redirect(32'h0000_5008);
        take_groups(8, 1'b0);
        end_test();
        wait_idle();

        // 0x2000 and 0x2200 share set 0, 0x2020 and 0x2220 share set 1
        begin_test("unaligned_conflict");
        send_redirect(32'h0000_2014);
        take_groups(4, 1'b0);
        wait_idle();
        send_redirect(32'h0000_221c);
        take_groups(4, 1'b0);
        wait_idle();
        send_redirect(32'h0000_2014);
        take_groups(4, 1'b0);
        end_test();

        total = errors + i_dut.i_chk.fail_count;
        $display("%0d tests, %0d groups checked, %0d check errors, %0d assertion failures",
                 tests_done, groups_seen, errors, i_dut.i_chk.fail_count);
        if (total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fetch_unit.f ====
src/fetch_pkg.sv
src/icache_pkg.sv
src/pc_gen.sv
src/if1_stage.sv
src/icache.sv
src/fetch_unit.sv
bench/fetch_unit_chk.sv
bench/fetch_unit_tb.sv

// ==== src/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // Byte address on the fetch path
    typedef logic [31:0] addr_t;

    // One instruction word as it leaves the front end
    typedef logic [31:0] inst_t;

endpackage

`default_nettype wire

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter int               IF_WIDTH = 2,
    parameter int               SETS     = 16,
    parameter fetch_pkg::addr_t RESET_PC = 32'h0000_1000
) (
    input  logic              clk,
    input  logic              rst,

    // From the back end
    input  logic              redirect,
    input  fetch_pkg::addr_t  redirect_pc,

    // To decode
    output logic              nxt_valid,
    input  logic              nxt_ready,
    output fetch_pkg::addr_t  pc,
    output fetch_pkg::inst_t  insts [IF_WIDTH],

    // Line reads from memory
    output fetch_pkg::addr_t  dfp_addr,
    output logic              dfp_read,
    input  icache_pkg::line_t dfp_rdata,
    input  logic              dfp_resp
);
    import fetch_pkg::*;

    logic  prv_valid;
    logic  prv_ready;
    addr_t pc_next;

    addr_t ufp_addr;
    logic  ufp_read;
    inst_t ufp_rdata [IF_WIDTH];
    logic  ufp_resp;
    logic  kill;

    pc_gen #(
        .IF_WIDTH (IF_WIDTH),
        .RESET_PC (RESET_PC)
    ) i_pc_gen (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .prv_valid   (prv_valid),
        .prv_ready   (prv_ready),
        .pc_next     (pc_next)
    );

    // A redirect is the flush for the whole front end
    if1_stage #(
        .IF_WIDTH (IF_WIDTH)
    ) i_if1_stage (
        .clk       (clk),
        .rst       (rst),
        .flush     (redirect),
        .prv_valid (prv_valid),
        .prv_ready (prv_ready),
        .nxt_valid (nxt_valid),
        .nxt_ready (nxt_ready),
        .pc_next   (pc_next),
        .pc        (pc),
        .insts     (insts),
        .ufp_addr  (ufp_addr),
        .ufp_read  (ufp_read),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .kill      (kill)
    );

    icache #(
        .IF_WIDTH (IF_WIDTH),
        .SETS     (SETS)
    ) i_icache (
        .clk       (clk),
        .rst       (rst),
        .ufp_addr  (ufp_addr),
        .ufp_read  (ufp_read),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .kill      (kill),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

endmodule

`default_nettype wire

// ==== src/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int IF_WIDTH = 2,
    parameter int SETS     = 16
) (
    input  logic              clk,
    input  logic              rst,

    // Fetch side
    input  fetch_pkg::addr_t  ufp_addr,
    input  logic              ufp_read,
    output fetch_pkg::inst_t  ufp_rdata [IF_WIDTH],
    output logic              ufp_resp,
    input  logic              kill,

    // Memory side, one line per read
    output fetch_pkg::addr_t  dfp_addr,
    output logic              dfp_read,
    input  icache_pkg::line_t dfp_rdata,
    input  logic              dfp_resp
);
    import fetch_pkg::*;
    import icache_pkg::*;

    localparam int INDEX_BITS = $clog2(SETS);
    localparam int TAG_BITS   = $bits(addr_t) - OFFSET_BITS - INDEX_BITS;
    localparam int WSEL_BITS  = $clog2(LINE_WORDS);

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   tag_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MISS,
        ST_FILL
    } state_t;

    state_t state;

    logic [SETS-1:0] valid_arr;
    tag_t            tag_arr  [SETS];
    line_t           data_arr [SETS];

    // Request being served, and one parked behind a miss
    addr_t req_addr;
    logic  req_live;
    addr_t pend_addr;
    logic  pend_valid;

    index_t               req_index;
    tag_t                 req_tag;
    offset_t              req_offset;
    logic [WSEL_BITS-1:0] word_base;
    line_t                req_line;
    logic                 hit;
    logic                 load_new;
    logic                 load_pend;
    logic                 fill_we;

    assign req_offset = req_addr[OFFSET_BITS-1:0];
    assign req_index  = req_addr[OFFSET_BITS +: INDEX_BITS];
    assign req_tag    = req_addr[$bits(addr_t)-1 -: TAG_BITS];
    assign word_base  = req_offset[OFFSET_BITS-1:2];
    assign req_line   = data_arr[req_index];
    assign hit        = valid_arr[req_index] && (tag_arr[req_index] == req_tag);

    // Outside a miss a new request goes straight into the request register
    assign load_new  = ufp_read && (state != ST_MISS);
    assign load_pend = (state == ST_FILL) && pend_valid && !ufp_read && !kill;
    assign fill_we   = (state == ST_MISS) && dfp_resp;

    assign dfp_read = (state == ST_MISS);
    assign dfp_addr = {req_addr[$bits(addr_t)-1:OFFSET_BITS], offset_t'(0)};

    // Group is aligned, so it never runs past the end of the line
    always_comb begin
        for (int i = 0; i < IF_WIDTH; i++) begin
            ufp_rdata[i] = req_line[(int'(word_base) + i) * 32 +: 32];
        end
    end

    // Dead requests get no response
    always_comb begin
        case (state)
            ST_LOOKUP: ufp_resp = hit && req_live && !kill;
            ST_FILL:   ufp_resp = req_live && !kill;
            default:   ufp_resp = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (load_new) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (load_new) begin
                        state <= ST_LOOKUP;
                    end else if (hit || !req_live || kill) begin
                        state <= ST_IDLE;
                    end else begin
                        state <= ST_MISS;
                    end
                end
                ST_MISS: begin
                    // Line is fetched even if the request was killed
                    if (dfp_resp) begin
                        state <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (load_new || load_pend) begin
                        state <= ST_LOOKUP;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_live <= 1'b0;
        end else if (load_new || load_pend) begin
            req_live <= 1'b1;
        end else if (kill) begin
            req_live <= 1'b0;
        end
    end

    // Only the newest request behind a miss survives
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid <= 1'b0;
        end else if ((state == ST_MISS) && ufp_read) begin
            pend_valid <= 1'b1;
        end else if ((state == ST_FILL) || kill) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_new) begin
            req_addr <= ufp_addr;
        end else if (load_pend) begin
            req_addr <= pend_addr;
        end
        if ((state == ST_MISS) && ufp_read) begin
            pend_addr <= ufp_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_arr <= '0;
        end else if (fill_we) begin
            valid_arr[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_arr[req_index]  <= req_tag;
            data_arr[req_index] <= dfp_rdata;
        end
    end

endmodule

`default_nettype wire

// ==== src/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

    // Line geometry shared by the cache and the memory side
    localparam int LINE_BYTES  = 32;
    localparam int LINE_WORDS  = LINE_BYTES / 4;
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);

    // A whole line as it comes back from memory, word 0 in the low bits
    typedef logic [LINE_WORDS*32-1:0] line_t;

    // Byte offset inside a line
    typedef logic [OFFSET_BITS-1:0] offset_t;

endpackage

`default_nettype wire

// ==== src/if1_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module if1_stage #(
    parameter int IF_WIDTH = 2
) (
    input  logic             clk,
    input  logic             rst,

    input  logic             flush,

    // Handshake towards pc_gen
    input  logic             prv_valid,
    output logic             prv_ready,

    // Handshake towards decode
    output logic             nxt_valid,
    input  logic             nxt_ready,

    input  fetch_pkg::addr_t pc_next,
    output fetch_pkg::addr_t pc,
    output fetch_pkg::inst_t insts [IF_WIDTH],

    // Cache request and response
    output fetch_pkg::addr_t ufp_addr,
    output logic             ufp_read,
    input  fetch_pkg::inst_t ufp_rdata [IF_WIDTH],
    input  logic             ufp_resp,
    output logic             kill
);
    import fetch_pkg::*;

    logic  grp_valid;
    logic  resp_pending;
    logic  accept;
    inst_t hold [IF_WIDTH];

    // Room for a new group when empty, when the current one leaves, or on flush
    assign prv_ready = !grp_valid || (nxt_valid && nxt_ready) || flush;
    assign accept    = prv_valid && prv_ready;

    // Group is presented once its data is back, never in a flush cycle
    assign nxt_valid = grp_valid && !(resp_pending && !ufp_resp) && !flush;

    assign ufp_addr = pc_next;
    assign ufp_read = accept;
    assign kill     = flush;

    always_ff @(posedge clk) begin
        if (accept) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grp_valid <= 1'b0;
        end else if (prv_ready) begin
            grp_valid <= prv_valid;
        end
    end

    // Waiting on the cache for the group in the stage
    always_ff @(posedge clk) begin
        if (rst) begin
            resp_pending <= 1'b0;
        end else if (accept) begin
            resp_pending <= 1'b1;
        end else if (ufp_resp || flush) begin
            resp_pending <= 1'b0;
        end
    end

    // Response lasts one cycle, keep it for a stalled decode
    always_ff @(posedge clk) begin
        if (ufp_resp) begin
            hold <= ufp_rdata;
        end
    end

    always_comb begin
        for (int i = 0; i < IF_WIDTH; i++) begin
            insts[i] = ufp_resp ? ufp_rdata[i] : hold[i];
        end
    end

endmodule

`default_nettype wire

// ==== src/pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_gen #(
    parameter int               IF_WIDTH = 2,
    parameter fetch_pkg::addr_t RESET_PC = 32'h0000_1000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             redirect,
    input  fetch_pkg::addr_t redirect_pc,
    output logic             prv_valid,
    input  logic             prv_ready,
    output fetch_pkg::addr_t pc_next
);
    import fetch_pkg::*;

    localparam int    GROUP_BYTES = IF_WIDTH * 4;
    localparam addr_t GROUP_MASK  = ~addr_t'(GROUP_BYTES - 1);

    addr_t fetch_ptr;
    logic  take;

    // Redirect target overrides the pointer in the same cycle
    assign pc_next = redirect ? (redirect_pc & GROUP_MASK) : fetch_ptr;
    assign take    = prv_valid && prv_ready;

    // Always a request to offer once out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            prv_valid <= 1'b0;
        end else begin
            prv_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_ptr <= RESET_PC & GROUP_MASK;
        end else if (take) begin
            fetch_ptr <= pc_next + addr_t'(GROUP_BYTES);
        end else if (redirect) begin
            // Target not taken this cycle, offer it next
            fetch_ptr <= pc_next;
        end
    end

endmodule

`default_nettype wire
